// ==== rtl/gb2_cfg_pkg.sv ====
`default_nettype none
// Configuration package for the two-console glue logic
// User options, download kinds, bootrom checksums and save block limits

package gb2_cfg_pkg;

	//////////////////////////////////////////////////
	// User options
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		SYS_AUTO,
		SYS_DMG,
		SYS_CGB,
		SYS_DUCK
	} sys_sel_t;

	typedef enum logic [1:0] {
		AUD_GB1,
		AUD_GB2,
		AUD_MIX,
		AUD_SPLIT
	} audio_sel_t;

	typedef struct packed {
		sys_sel_t   sys_sel;
		audio_sel_t audio_sel;
		logic       rom_to_gb2;
		logic       dupe_save;
		logic       autosave;
		logic       load_req;
		logic       save_req;
		logic       reset_req;
		logic       fast_boot;
		logic       gba_mode;
	} options_t;

	//////////////////////////////////////////////////
	// Loader file kinds
	//////////////////////////////////////////////////

	typedef logic [7:0] dl_index_t;

	localparam dl_index_t DL_PALETTE   = 8'd3;
	localparam dl_index_t DL_CGB_BOOT  = 8'd4;
	localparam dl_index_t DL_DMG_BOOT  = 8'd5;
	localparam dl_index_t DL_SGB_BOOT  = 8'd6;
	localparam dl_index_t DL_CART_ALT  = 8'h80;
	localparam dl_index_t DL_DUCK_CART = 8'h81;

	// Colour bootrom identification
	typedef logic [17:0] checksum_t;

	localparam checksum_t CKS_HOMEBREW_CGB = 18'h2CE10;
	localparam checksum_t CKS_ORIGINAL_CGB = 18'h2F3EA;

	// Four 24-bit colours in the top bits, low word unused
	typedef logic [127:0] palette_t;

	localparam palette_t PALETTE_RESET = 128'h828214517356305A5F1A3B4900000000;

	// Save file block limits, 512 byte blocks
	typedef logic [8:0] block_t;

	localparam block_t BK_LAST_BLOCK      = 9'h1FF;
	localparam block_t BK_LAST_BLOCK_DUPE = 9'h0FF;

endpackage

`default_nettype wire

// ==== rtl/gb2_io_pkg.sv ====
`default_nettype none
// I/O package for the two-console glue logic
// Loader and SD block ports, audio samples and joypad types

package gb2_io_pkg;
	import gb2_cfg_pkg::*;

	//////////////////////////////////////////////////
	// Loader and SD block ports
	//////////////////////////////////////////////////

	typedef struct packed {
		logic        download;
		logic        wr;
		logic [24:0] addr;
		logic [15:0] data;
		dl_index_t   index;
	} loader_t;

	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	typedef struct packed {
		logic        ack;
		logic [7:0]  buff_addr;
		logic [15:0] buff_data;
		logic        buff_wr;
		logic        img_mounted;
		logic        img_readonly;
		logic        img_nonempty;
	} sd_rsp_t;

	// Backup RAM write port toward the consoles
	typedef struct packed {
		logic [16:0] addr;
		logic [15:0] data;
		logic        wr_gb1;
		logic        wr_gb2;
	} bk_port_t;

	//////////////////////////////////////////////////
	// Audio and joypads
	//////////////////////////////////////////////////

	typedef logic signed [15:0] sample_t;

	// Bits 3:0 R L U D, bits 7:4 A B Select Start
	typedef logic [15:0] joy_word_t;
	typedef logic [1:0]  p54_t;
	typedef logic [3:0]  nibble_t;

endpackage

`default_nettype wire

// ==== rtl/download_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none
// Download decoder
// Classifies downloads, checks the colour bootrom and latches the system mode

module download_decoder import gb2_cfg_pkg::*, gb2_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  loader_t    loader,
	input  options_t   opts,
	input  logic       core_reset,
	input  logic [1:0] cart_gbc_flags,
	output logic       cart_download,
	output logic       boot_download,
	output logic       is_gbc,
	output logic       megaduck,
	output logic       fast_boot_en,
	output logic       boot_gba_en,
	output logic       real_cgb_boot,
	output palette_t   palette
);
	logic      duck_download;
	logic      palette_download;
	logic      cgb_boot_download;
	logic      dmg_boot_download;
	logic      sgb_boot_download;
	logic      boot_download_q;
	logic      custom_cgb_boot;
	logic      custom_dmg_boot;
	logic      fast_boot_avail;
	logic      gba_avail;
	checksum_t checksum;

	// Any slot with low bits 1 is a cartridge, plus the alternate slot
	assign cart_download = loader.download &&
		((loader.index[5:0] == 6'h01) || (loader.index == DL_CART_ALT));
	assign duck_download     = loader.download && (loader.index == DL_DUCK_CART);
	assign palette_download  = loader.download && (loader.index == DL_PALETTE);
	assign cgb_boot_download = loader.download && (loader.index == DL_CGB_BOOT);
	assign dmg_boot_download = loader.download && (loader.index == DL_DMG_BOOT);
	assign sgb_boot_download = loader.download && (loader.index == DL_SGB_BOOT);
	assign boot_download = cgb_boot_download | dmg_boot_download | sgb_boot_download;

	//////////////////////////////////////////////////
	// Bootrom features
	//////////////////////////////////////////////////

	// Fast boot only with homebrew colour bootroms or the built-in DMG one
	assign fast_boot_avail = !((is_gbc && custom_cgb_boot && (checksum != CKS_HOMEBREW_CGB)) ||
		(!is_gbc && custom_dmg_boot));
	assign gba_avail = !custom_cgb_boot || real_cgb_boot || (checksum == CKS_HOMEBREW_CGB);
	assign real_cgb_boot = (checksum == CKS_ORIGINAL_CGB);

	assign fast_boot_en = fast_boot_avail && opts.fast_boot;
	assign boot_gba_en  = gba_avail && opts.gba_mode;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			boot_download_q <= 1'b0;
			custom_cgb_boot <= 1'b0;
			custom_dmg_boot <= 1'b0;
			checksum        <= '0;
			palette         <= PALETTE_RESET;
		end else begin
			boot_download_q <= boot_download;
			if (cgb_boot_download)
				custom_cgb_boot <= 1'b1;
			if (dmg_boot_download)
				custom_dmg_boot <= 1'b1;

			// Byte sum over the whole colour bootrom
			if (cgb_boot_download && !boot_download_q)
				checksum <= '0;
			else if (cgb_boot_download && loader.wr)
				checksum <= checksum + checksum_t'(loader.data[15:8]) +
					checksum_t'(loader.data[7:0]);

			// Palette file arrives big end first, low byte of each word leads
			if (palette_download && loader.wr)
				palette <= {palette[111:0], loader.data[7:0], loader.data[15:8]};
		end
	end

	//////////////////////////////////////////////////
	// System mode, held while the consoles are in reset
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			is_gbc   <= (opts.sys_sel == SYS_CGB);
			megaduck <= (opts.sys_sel == SYS_DUCK);
		end else if (core_reset) begin
			if (duck_download)
				megaduck <= (opts.sys_sel == SYS_AUTO) || (opts.sys_sel == SYS_DUCK);
			else if (cart_download)
				megaduck <= (opts.sys_sel == SYS_DUCK);

			if (opts.sys_sel != SYS_AUTO)
				is_gbc <= (opts.sys_sel == SYS_CGB);
			else if (cart_download) begin
				// Alternate slot asks the cartridges, else the file extension decides
				if (loader.index[5:0] == 6'h00)
					is_gbc <= |cart_gbc_flags;
				else
					is_gbc <= (loader.index[7:6] == 2'b00);
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/backup_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none
// Backup RAM sequencer
// Loads and saves the save file block by block over the SD block port

module backup_sequencer import gb2_cfg_pkg::*, gb2_io_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  options_t opts,
	input  logic     cart_download,
	input  logic     osd_open,
	input  logic     cram_wr,
	input  logic     has_save,
	input  sd_rsp_t  sd_rsp,
	output sd_req_t  sd_req,
	output bk_port_t bk,
	output logic     loading,
	output logic     busy,
	output logic     save_pending
);
	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} bk_state_t;

	bk_state_t   state;
	logic [31:0] lba;
	logic        rd;
	logic        wr;
	logic        download_q;
	logic        load_q;
	logic        save_q;
	logic        ack_q;
	logic        bk_ena;
	logic        new_load;
	logic        save_ok;
	logic        load_trig;
	logic        save_trig;
	logic        download_end;
	logic        last_block;

	assign save_ok      = has_save && bk_ena;
	assign load_trig    = opts.load_req | new_load;
	assign save_trig    = opts.save_req | (save_pending & osd_open & opts.autosave);
	assign download_end = download_q && !cart_download;
	assign busy         = (state == BK_XFER);

	// Dupe mode only needs the first console's half of the file
	assign last_block = (lba[8:0] == BK_LAST_BLOCK) ||
		(opts.dupe_save && (lba[8:0] == BK_LAST_BLOCK_DUPE));

	assign sd_req = '{lba: lba, rd: rd, wr: wr};

	//////////////////////////////////////////////////
	// Block routing toward the consoles
	//////////////////////////////////////////////////

	// Word address inside one console's save RAM
	assign bk.addr   = {1'b0, lba[7:0], sd_rsp.buff_addr};
	assign bk.data   = sd_rsp.buff_data;
	assign bk.wr_gb1 = !lba[8] && !(opts.rom_to_gb2 && opts.dupe_save) &&
		sd_rsp.buff_wr && sd_rsp.ack;
	assign bk.wr_gb2 = (lba[8] || opts.dupe_save) && sd_rsp.buff_wr && sd_rsp.ack;

	//////////////////////////////////////////////////
	// Save file bookkeeping
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q   <= 1'b0;
			load_q       <= 1'b0;
			save_q       <= 1'b0;
			ack_q        <= 1'b0;
			bk_ena       <= 1'b0;
			new_load     <= 1'b0;
			save_pending <= 1'b0;
		end else begin
			download_q <= cart_download;
			load_q     <= load_trig;
			save_q     <= save_trig;
			ack_q      <= sd_rsp.ack;

			// Host mounts the save image near the end of the download
			if (cart_download && sd_rsp.img_mounted && !sd_rsp.img_readonly)
				bk_ena <= 1'b1;
			else if (!download_q && cart_download)
				bk_ena <= 1'b0;

			if (download_end && save_ok)
				new_load <= 1'b1;
			else if (busy)
				new_load <= 1'b0;

			if (cram_wr && !osd_open && save_ok)
				save_pending <= 1'b1;
			else if (busy)
				save_pending <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Transfer FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= BK_IDLE;
			lba     <= '0;
			rd      <= 1'b0;
			wr      <= 1'b0;
			loading <= 1'b0;
		end else begin
			// Request is dropped once the host takes it
			if (!ack_q && sd_rsp.ack) begin
				rd <= 1'b0;
				wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (download_end && sd_rsp.img_nonempty && bk_ena) begin
						state   <= BK_XFER;
						loading <= 1'b1;
						lba     <= '0;
						rd      <= 1'b1;
						wr      <= 1'b0;
					end else if (bk_ena &&
						((load_trig && !load_q) || (save_trig && !save_q))) begin
						state   <= BK_XFER;
						loading <= load_trig;
						lba     <= '0;
						rd      <= load_trig;
						wr      <= !load_trig;
					end
				end
				BK_XFER: begin
					// Next block once the host has finished this one
					if (ack_q && !sd_rsp.ack) begin
						if (last_block) begin
							state   <= BK_IDLE;
							loading <= 1'b0;
						end else begin
							lba <= lba + 32'd1;
							rd  <= loading;
							wr  <= !loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/audio_select.sv ====
`timescale 1ns/1ns
`default_nettype none
// Audio select
// Routes or mixes the stereo output of the two consoles

module audio_select import gb2_cfg_pkg::*, gb2_io_pkg::*; (
	input  audio_sel_t sel,
	input  sample_t    gb1_l,
	input  sample_t    gb1_r,
	input  sample_t    gb2_l,
	input  sample_t    gb2_r,
	output sample_t    out_l,
	output sample_t    out_r
);

	// Halving first keeps any sum of two samples in range
	function automatic sample_t half(input sample_t s);
		return s >>> 1;
	endfunction

	always_comb begin
		case (sel)
			AUD_GB1: begin
				out_l = gb1_l;
				out_r = gb1_r;
			end
			AUD_GB2: begin
				out_l = gb2_l;
				out_r = gb2_r;
			end
			AUD_MIX: begin
				out_l = half(gb1_l) + half(gb2_l);
				out_r = half(gb1_r) + half(gb2_r);
			end
			default: begin
				// Console 1 mono on the left, console 2 mono on the right
				out_l = half(gb1_l) + half(gb1_r);
				out_r = half(gb2_l) + half(gb2_r);
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/gb2_glue_top.sv ====
`timescale 1ns/1ns
`default_nettype none
// Two-console glue top level
// Downloads, core reset, backup RAM, audio routing and joypad matrices

module gb2_glue_top import gb2_cfg_pkg::*, gb2_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  options_t   opts,
	input  loader_t    loader,
	input  logic       osd_open,
	input  sd_rsp_t    sd_rsp,
	output sd_req_t    sd_req,
	output bk_port_t   bk,
	input  logic [1:0] cart_gbc_flags,
	input  logic [1:0] cart_has_save,
	input  logic [1:0] cram_wr,
	input  joy_word_t  joy0,
	input  joy_word_t  joy1,
	input  p54_t       p54_gb1,
	input  p54_t       p54_gb2,
	output nibble_t    joy_gb1,
	output nibble_t    joy_gb2,
	input  sample_t    gb1_l,
	input  sample_t    gb1_r,
	input  sample_t    gb2_l,
	input  sample_t    gb2_r,
	output sample_t    audio_l,
	output sample_t    audio_r,
	output logic       core_reset,
	output logic       is_gbc,
	output logic       megaduck,
	output logic       fast_boot_en,
	output logic       boot_gba_en,
	output logic       real_cgb_boot,
	output palette_t   palette,
	output logic       save_pending
);
	logic cart_download;
	logic boot_download;
	logic loading;

	// Active low matrix, p54 high deselects a half
	function automatic nibble_t joy_matrix(input joy_word_t joy, input p54_t p54);
		nibble_t dir_half;
		nibble_t btn_half;
		// D U L R
		dir_half = ~{joy[3], joy[2], joy[1], joy[0]} | {4{p54[0]}};
		// Start Select B A
		btn_half = ~{joy[7], joy[6], joy[5], joy[4]} | {4{p54[1]}};
		return dir_half & btn_half;
	endfunction

	assign joy_gb1 = joy_matrix(joy0, p54_gb1);
	assign joy_gb2 = joy_matrix(joy1, p54_gb2);

	// Consoles stay in reset through downloads and backup loads
	assign core_reset = reset | opts.reset_req | cart_download | boot_download | loading;

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////

	download_decoder decoder_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.loader         (loader),
		.opts           (opts),
		.core_reset     (core_reset),
		.cart_gbc_flags (cart_gbc_flags),
		.cart_download  (cart_download),
		.boot_download  (boot_download),
		.is_gbc         (is_gbc),
		.megaduck       (megaduck),
		.fast_boot_en   (fast_boot_en),
		.boot_gba_en    (boot_gba_en),
		.real_cgb_boot  (real_cgb_boot),
		.palette        (palette)
	);

	backup_sequencer backup_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.opts          (opts),
		.cart_download (cart_download),
		.osd_open      (osd_open),
		.cram_wr       (|cram_wr),
		.has_save      (|cart_has_save),
		.sd_rsp        (sd_rsp),
		.sd_req        (sd_req),
		.bk            (bk),
		.loading       (loading),
		.busy          (),
		.save_pending  (save_pending)
	);

	audio_select audio_i (
		.sel   (opts.audio_sel),
		.gb1_l (gb1_l),
		.gb1_r (gb1_r),
		.gb2_l (gb2_l),
		.gb2_r (gb2_r),
		.out_l (audio_l),
		.out_r (audio_r)
	);

endmodule

`default_nettype wire

// ==== bench/tb_gb2_glue.sv ====
`timescale 1ns/1ns
`default_nettype none
// Testbench for the two-console glue top level
// Table driven checks of downloads, audio, joypads and backup RAM transfers

module tb_gb2_glue import gb2_cfg_pkg::*, gb2_io_pkg::*;;
	logic       clk_sys = 1'b0;
	logic       reset = 1'b1;
	options_t   opts;
	loader_t    loader;
	logic       osd_open;
	sd_rsp_t    sd_rsp;
	sd_req_t    sd_req;
	bk_port_t   bk;
	logic [1:0] cart_gbc_flags;
	logic [1:0] cart_has_save;
	logic [1:0] cram_wr;
	joy_word_t  joy0;
	joy_word_t  joy1;
	p54_t       p54_gb1;
	p54_t       p54_gb2;
	nibble_t    joy_gb1;
	nibble_t    joy_gb2;
	sample_t    gb1_l;
	sample_t    gb1_r;
	sample_t    gb2_l;
	sample_t    gb2_r;
	sample_t    audio_l;
	sample_t    audio_r;
	logic       core_reset;
	logic       is_gbc;
	logic       megaduck;
	logic       fast_boot_en;
	logic       boot_gba_en;
	logic       real_cgb_boot;
	palette_t   palette;
	logic       save_pending;

	int          errors = 0;
	int          checks = 0;
	int          gaps = 0;
	logic [31:0] seed = 32'h1ef0_f0d2;
	logic [15:0] dl_words[$];
	logic        img_mounted = 1'b0;

	// SD host model state
	logic        h_ack = 1'b0;
	logic        h_buff_wr = 1'b0;
	logic [7:0]  h_addr = '0;
	logic [15:0] h_data = '0;
	logic        host_rd = 1'b0;
	logic [31:0] exp_lba = '0;
	logic [31:0] cur_lba = '0;
	int          ack_left = 0;
	int          beat = 0;
	int          idle = 0;
	int          rd_count = 0;
	int          wr_count = 0;
	int          lba_bad = 0;
	int          gb1_n = 0;
	int          gb2_n = 0;
	int          port_bad = 0;

	assign sd_rsp = '{ack: h_ack, buff_addr: h_addr, buff_data: h_data, buff_wr: h_buff_wr,
		img_mounted: img_mounted, img_readonly: 1'b0, img_nonempty: 1'b1};

	gb2_glue_top dut_i (.*);

	always #20 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic give_up(input string what);
		$display("Timeout: %s did not happen in time", what);
		$display("checks %0d, errors %0d", checks, errors);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	// First loader cycle carries no write so the checksum clears
	task automatic stream_download(input dl_index_t idx, input logic mount);
		step();
		loader.download = 1'b1;
		loader.index = idx;
		loader.wr = 1'b0;
		#1 gaps += !core_reset;
		foreach (dl_words[i]) begin
			step();
			loader.wr = 1'b1;
			loader.addr = 25'(i);
			loader.data = dl_words[i];
			#1 gaps += !core_reset;
		end
		step();
		loader.wr = 1'b0;
		img_mounted = mount;
		step();
		img_mounted = 1'b0;
		loader.download = 1'b0;
		repeat (2) step();
	endtask

	function automatic nibble_t expected_nibble(input joy_word_t j, input p54_t p);
		nibble_t n;
		for (int i = 0; i < 4; i++)
			n[i] = (p[0] | !j[i]) & (p[1] | !j[i + 4]);
		return n;
	endfunction

	//////////////////////////////////////////////////
	// SD host and backup port monitor
	//////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		#2;
		if (ack_left > 0) begin
			ack_left--;
			h_buff_wr = host_rd && (beat < 256);
			h_addr = 8'(beat);
			h_data = 16'(beat * 3 + cur_lba);
			beat++;
			if (ack_left == 0) begin
				h_ack = 1'b0;
				h_buff_wr = 1'b0;
			end
		end else if (sd_req.rd || sd_req.wr) begin
			// Long gap between requests means a new transfer from block 0
			if (idle > 4)
				exp_lba = '0;
			if (sd_req.lba !== exp_lba)
				lba_bad++;
			cur_lba = sd_req.lba;
			exp_lba = sd_req.lba + 1;
			host_rd = sd_req.rd;
			rd_count += sd_req.rd;
			wr_count += !sd_req.rd;
			h_ack = 1'b1;
			beat = 0;
			idle = 0;
			ack_left = sd_req.rd ? 258 : 6;
		end else begin
			idle++;
		end
	end

	always @(negedge clk_sys) begin
		gb1_n += bk.wr_gb1;
		gb2_n += bk.wr_gb2;
		if ((bk.wr_gb1 || bk.wr_gb2) &&
			((bk.addr !== {1'b0, cur_lba[7:0], h_addr}) || (bk.data !== h_data)))
			port_bad++;
	end

	//////////////////////////////////////////////////
	// Stimulus tables
	//////////////////////////////////////////////////

	// Word source per entry is random, homebrew sum or original sum
	int boot_tab [3] = '{0, 1, 2};

	typedef struct packed {
		dl_index_t  index;
		logic [1:0] flags;
		logic       exp_gbc;
		logic       exp_duck;
	} cart_row_t;
	cart_row_t cart_tab [5] = '{'{8'h80, 2'b10, 1'b1, 1'b0}, '{8'h80, 2'b00, 1'b0, 1'b0},
		'{8'h01, 2'b00, 1'b1, 1'b0}, '{DL_DUCK_CART, 2'b11, 1'b0, 1'b1},
		'{8'h41, 2'b11, 1'b0, 1'b0}};

	audio_sel_t audio_tab [4] = '{AUD_GB1, AUD_GB2, AUD_MIX, AUD_SPLIT};

	typedef struct packed {
		joy_word_t j0;
		joy_word_t j1;
		p54_t      p1;
		p54_t      p2;
	} joy_row_t;
	joy_row_t joy_tab [4] = '{'{16'h0000, 16'h00FF, 2'b00, 2'b00},
		'{16'h0005, 16'h00A0, 2'b01, 2'b10}, '{16'h0030, 16'h0009, 2'b10, 2'b01},
		'{16'h00C3, 16'h003C, 2'b11, 2'b00}};

	typedef struct packed {
		logic dupe;
		logic rom2;
		int   blocks;
		int   gb1;
		int   gb2;
	} load_row_t;
	load_row_t load_tab [3] = '{'{1'b0, 1'b0, 512, 65536, 65536},
		'{1'b1, 1'b0, 256, 65536, 65536}, '{1'b1, 1'b1, 256, 0, 65536}};

	initial begin
		checksum_t cks;
		checksum_t target;
		palette_t  exp_pal;
		sample_t   exp_l;
		sample_t   exp_r;
		logic [31:0] r;
		int n;
		int s_rd;
		int s_wr;
		int s_bad;
		int s_g1;
		int s_g2;
		int s_pb;

		opts = '0;
		opts.sys_sel = SYS_CGB;
		opts.fast_boot = 1'b1;
		opts.gba_mode = 1'b1;
		loader = '0;
		osd_open = 1'b0;
		cart_gbc_flags = '0;
		cart_has_save = '0;
		cram_wr = '0;
		{joy0, joy1, p54_gb1, p54_gb2} = '0;
		{gb1_l, gb1_r, gb2_l, gb2_r} = '0;
		repeat (10) @(posedge clk_sys);
		#2 reset = 1'b0;
		step();
		check_value(palette, PALETTE_RESET, "palette after reset");
		check_value({fast_boot_en, boot_gba_en, real_cgb_boot}, 3'b110, "boot flags after reset");

		// Colour bootroms
		foreach (boot_tab[k]) begin
			dl_words.delete();
			cks = '0;
			target = (boot_tab[k] == 1) ? CKS_HOMEBREW_CGB : CKS_ORIGINAL_CGB;
			if (boot_tab[k] == 0) begin
				for (int i = 0; i < 64; i++)
					dl_words.push_back(16'(lcg_next() >> 16));
			end else begin
				while (cks != target) begin
					r[15:8] = ((target - cks) > 255) ? 8'hFF : 8'(target - cks);
					cks += r[15:8];
					r[7:0] = ((target - cks) > 255) ? 8'hFF : 8'(target - cks);
					cks += r[7:0];
					dl_words.push_back(r[15:0]);
				end
			end
			cks = '0;
			foreach (dl_words[i])
				cks += checksum_t'(dl_words[i][15:8]) + checksum_t'(dl_words[i][7:0]);
			stream_download(DL_CGB_BOOT, 1'b0);
			check_value(fast_boot_en, cks == CKS_HOMEBREW_CGB, "fast_boot_en colour boot");
			check_value(boot_gba_en, (cks == CKS_HOMEBREW_CGB) || (cks == CKS_ORIGINAL_CGB),
				"boot_gba_en colour boot");
			check_value(real_cgb_boot, cks == CKS_ORIGINAL_CGB, "real_cgb_boot");
		end

		// DMG bootrom in non-colour mode blocks fast boot
		opts.sys_sel = SYS_DMG;
		dl_words = '{16'h31FE, 16'hFFAF, 16'h21FF, 16'h9F32};
		stream_download(DL_DMG_BOOT, 1'b0);
		check_value(is_gbc, 1'b0, "is_gbc in DMG mode");
		check_value(fast_boot_en, 1'b0, "fast_boot_en with DMG boot");
		check_value(gaps, 0, "core_reset during bootrom download");

		// Palette
		exp_pal = PALETTE_RESET;
		dl_words.delete();
		for (int i = 0; i < 8; i++) begin
			r = lcg_next();
			dl_words.push_back(r[23:8]);
			exp_pal = {exp_pal[111:0], r[15:8], r[23:16]};
		end
		stream_download(DL_PALETTE, 1'b0);
		check_value(palette, exp_pal, "palette");

		// Cartridges in auto mode
		opts.sys_sel = SYS_AUTO;
		foreach (cart_tab[k]) begin
			cart_gbc_flags = cart_tab[k].flags;
			gaps = 0;
			dl_words = '{16'h1234, 16'h5678};
			stream_download(cart_tab[k].index, 1'b0);
			check_value(is_gbc, cart_tab[k].exp_gbc, "is_gbc after cartridge");
			check_value(megaduck, cart_tab[k].exp_duck, "megaduck after cartridge");
			check_value(gaps, 0, "core_reset during cartridge download");
		end

		// Audio
		foreach (audio_tab[k]) begin
			opts.audio_sel = audio_tab[k];
			{gb1_l, gb1_r} = lcg_next();
			{gb2_l, gb2_r} = lcg_next();
			case (audio_tab[k])
				AUD_GB1: {exp_l, exp_r} = {gb1_l, gb1_r};
				AUD_GB2: {exp_l, exp_r} = {gb2_l, gb2_r};
				AUD_MIX: begin
					exp_l = (gb1_l >>> 1) + (gb2_l >>> 1);
					exp_r = (gb1_r >>> 1) + (gb2_r >>> 1);
				end
				default: begin
					exp_l = (gb1_l >>> 1) + (gb1_r >>> 1);
					exp_r = (gb2_l >>> 1) + (gb2_r >>> 1);
				end
			endcase
			#5;
			check_value(audio_l, exp_l, "audio_l");
			check_value(audio_r, exp_r, "audio_r");
			step();
		end

		// Joypads
		foreach (joy_tab[k]) begin
			{joy0, joy1, p54_gb1, p54_gb2} = joy_tab[k];
			#5;
			check_value(joy_gb1, expected_nibble(joy0, p54_gb1), "joy_gb1");
			check_value(joy_gb2, expected_nibble(joy1, p54_gb2), "joy_gb2");
			step();
		end

		//////////////////////////////////////////////////
		// Backup RAM load after a cartridge download
		//////////////////////////////////////////////////

		cart_has_save = 2'b01;
		foreach (load_tab[k]) begin
			opts.dupe_save = load_tab[k].dupe;
			opts.rom_to_gb2 = load_tab[k].rom2;
			{s_rd, s_wr, s_bad, s_g1, s_g2, s_pb} = {rd_count, wr_count, lba_bad,
				gb1_n, gb2_n, port_bad};
			dl_words = '{16'hC3A0, 16'h0150};
			stream_download(8'h01, 1'b1);
			n = 0;
			while (rd_count == s_rd && n < 50) begin
				step();
				n++;
			end
			if (rd_count == s_rd)
				give_up("first backup read request");
			n = 0;
			while (core_reset && n < 200000) begin
				step();
				n++;
			end
			if (core_reset)
				give_up("end of backup load");
			repeat (4) step();
			check_value(rd_count - s_rd, load_tab[k].blocks, "read requests");
			check_value(wr_count - s_wr, 0, "write requests during load");
			check_value(lba_bad - s_bad, 0, "out of order lba during load");
			check_value(gb1_n - s_g1, load_tab[k].gb1, "wr_gb1 strobes");
			check_value(gb2_n - s_g2, load_tab[k].gb2, "wr_gb2 strobes");
			check_value(port_bad - s_pb, 0, "backup port address and data");
			check_value({sd_req.rd, sd_req.wr}, 2'b00, "request idle after load");
		end

		// Autosave when the OSD opens
		opts.dupe_save = 1'b0;
		opts.rom_to_gb2 = 1'b0;
		opts.autosave = 1'b1;
		{s_rd, s_wr, s_bad} = {rd_count, wr_count, lba_bad};
		cram_wr = 2'b01;
		step();
		cram_wr = 2'b00;
		step();
		check_value(save_pending, 1'b1, "save_pending after cram write");
		osd_open = 1'b1;
		n = 0;
		while ((wr_count - s_wr < 512 || h_ack || sd_req.wr) && n < 20000) begin
			step();
			n++;
		end
		if (wr_count - s_wr < 512 || h_ack || sd_req.wr)
			give_up("autosave write requests");
		repeat (10) step();
		check_value(wr_count - s_wr, 512, "write requests");
		check_value(rd_count - s_rd, 0, "read requests during save");
		check_value(lba_bad - s_bad, 0, "out of order lba during save");
		check_value(save_pending, 1'b0, "save_pending after autosave");
		osd_open = 1'b0;

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/gb2_cfg_pkg.sv
rtl/gb2_io_pkg.sv
rtl/download_decoder.sv
rtl/backup_sequencer.sv
rtl/audio_select.sv
rtl/gb2_glue_top.sv
bench/tb_gb2_glue.sv

// ==== Makefile ====
# Verilator build and run for the two-console glue testbench

VERILATOR ?= verilator
TOP       ?= tb_gb2_glue
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
